//--- kbd_event_out.sv
`timescale 1ns/1ps

module kbd_event_out (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            scan_received,
    input  logic [kbd_pkg::SCAN_W-1:0]      scancode,
    input  logic                            extended,
    input  logic                            released,
    input  logic                            frame_error,
    output logic                            key_valid,
    output logic [kbd_pkg::SCAN_W-1:0]      key_code,
    output logic                            key_ext,
    output logic                            key_up,
    output logic                            frame_err_seen,
    output logic [kbd_pkg::ERR_CNT_W-1:0]   err_count
);

    // ==================================================
    // Key event register
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            key_valid <= 1'b0;
        end else begin
            key_valid <= scan_received;
        end
    end

    always_ff @(posedge clk) begin
        if (scan_received) begin
            key_code <= scancode;
            key_ext  <= extended;
            key_up   <= released;
        end
    end

    // ==================================================
    // Frame error bookkeeping
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_err_seen <= 1'b0;
            err_count      <= '0;
        end else if (frame_error) begin
            frame_err_seen <= 1'b1;     // Sticky until the next reset
            if (err_count != '1) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

endmodule

//--- kbd_pkg.sv
package kbd_pkg;

    // ==================================================
    // PS/2 scancode set 2 byte stream
    // ==================================================

    localparam int SCAN_W = 8;  // One scancode byte per frame

    // Prefix bytes, consumed by the decoder only
    localparam logic [7:0] PREFIX_EXT = 8'hE0;  // Extended key follows
    localparam logic [7:0] PREFIX_REL = 8'hF0;  // Break code follows

    // ==================================================
    // Key tracking and receiver limits
    // ==================================================

    localparam int KEYMAP_DEPTH = 256;  // One entry per possible scancode

    // Idle clocks before a partial frame is thrown away
    localparam logic [10:0] RX_TIMEOUT = 11'd2000;

    localparam int ERR_CNT_W = 8;  // Saturating frame error counter

endpackage

//--- kbd_testdata.txt
# F <byte hex> <bad parity 0/1> | E <key_code hex> <key_ext> <key_up>
# C <kbclean> <err_count hex> | R reset and wait for the keymap sweep
C 1 00
# Plain make and break of 1C
F 1c 0
E 1c 0 0
C 0 00
F f0 0
F 1c 0
E 1c 0 1
C 1 00
# Plain 75 and extended 75 are separate keys
F 75 0
E 75 0 0
F e0 0
F 75 0
E 75 1 0
C 0 00
F f0 0
F 75 0
E 75 0 1
C 0 00
F e0 0
F f0 0
F 75 0
E 75 1 1
C 1 00
# Bad parity frames are counted and dropped
F 2b 1
C 1 01
F 2b 1
C 1 02
F 2b 0
E 2b 0 0
C 0 02
F f0 0
F 2b 0
E 2b 0 1
C 1 02
# Break of a key that was never made
F f0 0
F 4d 0
E 4d 0 1
C 1 02
# Hold 12, then reset clears everything
F 12 0
E 12 0 0
C 0 02
R
C 1 00
F 29 0
E 29 0 0
F f0 0
F 29 0
E 29 0 1
C 1 00

//--- keyboard_pressed_status.sv
`timescale 1ns/1ps

module keyboard_pressed_status (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        scan_received,
    input  logic [kbd_pkg::SCAN_W-1:0]  scancode,
    input  logic                        extended,
    input  logic                        released,
    output logic                        kbclean
);

    typedef enum logic [1:0] {
        RESETTING,
        UPDATING,
        SCANNING
    } state_t;

    state_t state;

    logic [kbd_pkg::KEYMAP_DEPTH-1:0] map_ne;  // Plain keys
    logic [kbd_pkg::KEYMAP_DEPTH-1:0] map_ex;  // E0 keys
    logic [kbd_pkg::SCAN_W-1:0]       addr;    // Sweep and scan address
    logic                             pressed_ne;
    logic                             pressed_ex;

    // Key captured on the strobe, written in UPDATING
    logic [kbd_pkg::SCAN_W-1:0] upd_code;
    logic                       upd_ext;
    logic                       upd_rel;

    // ==================================================
    // Keymap storage
    // ==================================================

    always_ff @(posedge clk) begin
        if (state == RESETTING) begin
            map_ne[addr] <= 1'b0;
            map_ex[addr] <= 1'b0;
        end else if (state == UPDATING) begin
            if (upd_ext) begin
                map_ex[upd_code] <= ~upd_rel;
            end else begin
                map_ne[upd_code] <= ~upd_rel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == SCANNING && scan_received) begin
            upd_code <= scancode;
            upd_ext  <= extended;
            upd_rel  <= released;
        end
    end

    // ==================================================
    // Sweep, update and scan control
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RESETTING;
            addr       <= '0;
            kbclean    <= 1'b1;
            pressed_ne <= 1'b0;
            pressed_ex <= 1'b0;
        end else begin
            case (state)
                RESETTING: begin
                    addr <= addr + 1'b1;
                    if (addr == '1) begin
                        state <= SCANNING;  // Wraps to address 0
                    end
                end
                UPDATING: begin
                    state      <= SCANNING;
                    addr       <= '0;
                    kbclean    <= 1'b0;     // Held low until a full scan
                    pressed_ne <= 1'b0;
                    pressed_ex <= 1'b0;
                end
                SCANNING: begin
                    if (scan_received) begin
                        state <= UPDATING;
                    end
                    addr <= addr + 1'b1;
                    if (addr == '1) begin
                        kbclean    <= ~(pressed_ne | pressed_ex | map_ne[addr] | map_ex[addr]);
                        pressed_ne <= 1'b0;
                        pressed_ex <= 1'b0;
                    end else begin
                        pressed_ne <= pressed_ne | map_ne[addr];
                        pressed_ex <= pressed_ex | map_ex[addr];
                    end
                end
                default: begin
                    state <= RESETTING;
                    addr  <= '0;
                end
            endcase
        end
    end

endmodule

//--- ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ps2_clk,
    input  logic                        ps2_data,
    output logic                        byte_valid,
    output logic [kbd_pkg::SCAN_W-1:0]  rx_byte,
    output logic                        frame_error
);

    // ==================================================
    // Line synchronizers and falling edge detection
    // ==================================================

    logic clk_s1, clk_s2, clk_prev;
    logic data_s1, data_s2;
    logic fall_q;                       // Registered falling edge of ps2_clk
    logic data_q;                       // Data bit that goes with fall_q

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_s1   <= 1'b1;           // Idle line is high
            clk_s2   <= 1'b1;
            clk_prev <= 1'b1;
            fall_q   <= 1'b0;
        end else begin
            clk_s1   <= ps2_clk;
            clk_s2   <= clk_s1;
            clk_prev <= clk_s2;
            fall_q   <= clk_prev & ~clk_s2;
        end
    end

    always_ff @(posedge clk) begin
        data_s1 <= ps2_data;
        data_s2 <= data_s1;
        data_q  <= data_s2;             // Stays aligned with fall_q
    end

    // ==================================================
    // Frame shifter, checks and idle timeout
    // ==================================================

    logic [9:0]  shift_q;               // First ten bits, LSB first
    logic [10:0] frame;                 // Complete frame once the stop bit lands
    logic [3:0]  bit_cnt;
    logic [$bits(kbd_pkg::RX_TIMEOUT)-1:0] idle_cnt;
    logic        frame_ok;

    assign frame = {data_q, shift_q};

    // Start low, odd parity over data and parity bit, stop high
    assign frame_ok = (frame[0] == 1'b0) && (^frame[9:1] == 1'b1) && (frame[10] == 1'b1);

    always_ff @(posedge clk) begin
        if (fall_q) begin
            shift_q <= frame[10:1];
        end
        if (fall_q && bit_cnt == 4'd10 && frame_ok) begin
            rx_byte <= frame[8:1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt     <= 4'd0;
            idle_cnt    <= '0;
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
            if (fall_q) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt     <= 4'd0;
                    byte_valid  <= frame_ok;
                    frame_error <= ~frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                if (idle_cnt == kbd_pkg::RX_TIMEOUT - 11'd1) begin
                    bit_cnt  <= 4'd0;   // Drop the partial frame and realign
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end else begin
                idle_cnt <= '0;
            end
        end
    end

endmodule

//--- ps2_keyboard_top.sv
`timescale 1ns/1ps

module ps2_keyboard_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            ps2_clk,
    input  logic                            ps2_data,
    output logic                            key_valid,
    output logic [kbd_pkg::SCAN_W-1:0]      key_code,
    output logic                            key_ext,
    output logic                            key_up,
    output logic                            kbclean,
    output logic                            frame_err_seen,
    output logic [kbd_pkg::ERR_CNT_W-1:0]   err_count
);

    logic                       byte_valid;
    logic [kbd_pkg::SCAN_W-1:0] rx_byte;
    logic                       frame_error;
    logic                       scan_received;
    logic [kbd_pkg::SCAN_W-1:0] scancode;
    logic                       extended;
    logic                       released;

    ps2_frame_rx u_rx (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .byte_valid  (byte_valid),
        .rx_byte     (rx_byte),
        .frame_error (frame_error)
    );

    scancode_decoder u_dec (
        .clk           (clk),
        .rst           (rst),
        .byte_valid    (byte_valid),
        .rx_byte       (rx_byte),
        .scan_received (scan_received),
        .scancode      (scancode),
        .extended      (extended),
        .released      (released)
    );

    keyboard_pressed_status u_status (
        .clk           (clk),
        .rst           (rst),
        .scan_received (scan_received),
        .scancode      (scancode),
        .extended      (extended),
        .released      (released),
        .kbclean       (kbclean)
    );

    kbd_event_out u_out (
        .clk            (clk),
        .rst            (rst),
        .scan_received  (scan_received),
        .scancode       (scancode),
        .extended       (extended),
        .released       (released),
        .frame_error    (frame_error),
        .key_valid      (key_valid),
        .key_code       (key_code),
        .key_ext        (key_ext),
        .key_up         (key_up),
        .frame_err_seen (frame_err_seen),
        .err_count      (err_count)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the PS/2 keyboard testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_ps2_keyboard \
    -o tb_ps2_keyboard_sim \
    && ./obj_dir/tb_ps2_keyboard_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx ">>> PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- scancode_decoder.sv
`timescale 1ns/1ps

module scancode_decoder (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        byte_valid,
    input  logic [kbd_pkg::SCAN_W-1:0]  rx_byte,
    output logic                        scan_received,
    output logic [kbd_pkg::SCAN_W-1:0]  scancode,
    output logic                        extended,
    output logic                        released
);

    logic ext_pend;                     // E0 seen, waiting for the key byte
    logic rel_pend;                     // F0 seen, waiting for the key byte
    logic is_ext;
    logic is_rel;

    assign is_ext = (rx_byte == kbd_pkg::PREFIX_EXT);
    assign is_rel = (rx_byte == kbd_pkg::PREFIX_REL);

    always_ff @(posedge clk) begin
        if (rst) begin
            ext_pend      <= 1'b0;
            rel_pend      <= 1'b0;
            scan_received <= 1'b0;
        end else begin
            scan_received <= 1'b0;
            if (byte_valid) begin
                if (is_ext) begin
                    ext_pend <= 1'b1;
                end else if (is_rel) begin
                    rel_pend <= 1'b1;
                end else begin
                    scan_received <= 1'b1;
                    ext_pend      <= 1'b0;  // Flags belong to this key only
                    rel_pend      <= 1'b0;
                end
            end
        end
    end

    // Key data is held until the next key byte
    always_ff @(posedge clk) begin
        if (byte_valid && !is_ext && !is_rel) begin
            scancode <= rx_byte;
            extended <= ext_pend;
            released <= rel_pend;
        end
    end

endmodule

//--- tb_ps2_keyboard.sv
`timescale 1ns/1ps

module tb_ps2_keyboard;

    localparam int PS2_HALF      = 16;      // System clocks per PS/2 clock half period
    localparam int IDLE_MIN      = 100;     // Shortest gap between frames
    localparam int EVENT_TIMEOUT = 2000;
    localparam int QUIET_CYCLES  = 400;     // Longer than the 262-cycle settle bound
    localparam int SWEEP_WAIT    = 300;     // Keymap clear after reset takes 256
    localparam int RESET_CYCLES  = 3;

    logic                            clk = 1'b0;
    logic                            rst;
    logic                            ps2_clk;
    logic                            ps2_data;
    logic                            key_valid;
    logic [kbd_pkg::SCAN_W-1:0]      key_code;
    logic                            key_ext;
    logic                            key_up;
    logic                            kbclean;
    logic                            frame_err_seen;
    logic [kbd_pkg::ERR_CNT_W-1:0]   err_count;

    logic [kbd_pkg::SCAN_W+1:0]      event_q[$];   // {key_up, key_ext, key_code}
    logic [31:0]                     seed;

    always #4 clk = ~clk;

    ps2_keyboard_top uut (
        .clk            (clk),
        .rst            (rst),
        .ps2_clk        (ps2_clk),
        .ps2_data       (ps2_data),
        .key_valid      (key_valid),
        .key_code       (key_code),
        .key_ext        (key_ext),
        .key_up         (key_up),
        .kbclean        (kbclean),
        .frame_err_seen (frame_err_seen),
        .err_count      (err_count)
    );

    // Each key event is queued in the order the DUT reports it
    always @(negedge clk) begin
        if (key_valid === 1'b1) begin
            event_q.push_back({key_up, key_ext, key_code});
        end
    end

    // ==================================================
    // Helpers
    // ==================================================

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        wait_cycles(RESET_CYCLES);
        rst = 1'b0;
        event_q.delete();
        wait_cycles(SWEEP_WAIT);
    endtask

    // Start bit, eight data bits LSB first, parity, stop bit
    task automatic send_frame(input logic [kbd_pkg::SCAN_W-1:0] value, input logic bad_parity);
        logic [10:0] frame;
        logic        parity;
        parity = ~^value;                   // Odd count of ones over data and parity
        if (bad_parity) begin
            parity = ~parity;
        end
        frame = {1'b1, parity, value, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = frame[i];            // Data moves while ps2_clk is high
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b0;
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        seed = next_random(seed);
        wait_cycles(IDLE_MIN + int'(seed[5:0]));
    endtask

    task automatic expect_event(input logic [kbd_pkg::SCAN_W-1:0] code,
                                input logic ext, input logic up);
        int                         waited;
        logic [kbd_pkg::SCAN_W+1:0] ev;
        waited = 0;
        while (event_q.size() == 0 && waited < EVENT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (event_q.size() != 0) else report_failure($sformatf(
            "Timeout: the key event for code %h ext %0d up %0d never arrived", code, ext, up));
        ev = event_q.pop_front();
        assert (ev[kbd_pkg::SCAN_W-1:0] === code) else report_failure($sformatf(
            "ERR key_code: got %h expected %h", ev[kbd_pkg::SCAN_W-1:0], code));
        assert (ev[kbd_pkg::SCAN_W] === ext) else report_failure($sformatf(
            "ERR key_ext: got %h expected %h", ev[kbd_pkg::SCAN_W], ext));
        assert (ev[kbd_pkg::SCAN_W+1] === up) else report_failure($sformatf(
            "ERR key_up: got %h expected %h", ev[kbd_pkg::SCAN_W+1], up));
    endtask

    task automatic check_levels(input logic exp_clean,
                                input logic [kbd_pkg::ERR_CNT_W-1:0] exp_cnt);
        logic exp_seen;
        exp_seen = (exp_cnt != '0);         // Sticky flag is set by any counted error
        wait_cycles(QUIET_CYCLES);
        assert (event_q.size() == 0) else report_failure(
            "A key event appeared where none was expected");
        assert (kbclean === exp_clean) else report_failure($sformatf(
            "ERR kbclean: got %h expected %h", kbclean, exp_clean));
        assert (err_count === exp_cnt) else report_failure($sformatf(
            "ERR err_count: got %h expected %h", err_count, exp_cnt));
        assert (frame_err_seen === exp_seen) else report_failure($sformatf(
            "ERR frame_err_seen: got %h expected %h", frame_err_seen, exp_seen));
    endtask

    // ==================================================
    // Replay of the stimulus file
    // ==================================================

    initial begin
        int    fd;
        int    n;
        int    fields;
        int    val_a;
        int    val_b;
        int    val_c;
        byte   kind;
        string line;

        rst      = 1'b1;
        ps2_clk  = 1'b1;                    // Both PS/2 lines idle high
        ps2_data = 1'b1;
        seed     = 32'd94670;
        apply_reset();

        fd = $fopen("kbd_testdata.txt", "r");
        assert (fd != 0) else report_failure("Could not open kbd_testdata.txt");

        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0) begin
                kind = line.getc(0);
                case (kind)
                    "F": begin
                        fields = $sscanf(line, "F %h %h", val_a, val_b);
                        assert (fields == 2) else report_failure("Malformed frame record");
                        send_frame(val_a[kbd_pkg::SCAN_W-1:0], val_b[0]);
                    end
                    "E": begin
                        fields = $sscanf(line, "E %h %h %h", val_a, val_b, val_c);
                        assert (fields == 3) else report_failure("Malformed event record");
                        expect_event(val_a[kbd_pkg::SCAN_W-1:0], val_b[0], val_c[0]);
                    end
                    "C": begin
                        fields = $sscanf(line, "C %h %h", val_a, val_b);
                        assert (fields == 2) else report_failure("Malformed level record");
                        check_levels(val_a[0], val_b[kbd_pkg::ERR_CNT_W-1:0]);
                    end
                    "R": apply_reset();
                    "#", "\n", "\r", " ": begin
                    end
                    default: report_failure("Unknown record kind in kbd_testdata.txt");
                endcase
            end
        end
        $fclose(fd);

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- verilog.f
kbd_pkg.sv
ps2_frame_rx.sv
scancode_decoder.sv
keyboard_pressed_status.sv
kbd_event_out.sv
ps2_keyboard_top.sv
tb_ps2_keyboard.sv
